// ==== ib_replay_testdata.txt ====
# test dec0 dec1 blk0 blk1 match0 match1 flush0 flush1 tag0 tag1 (hex)
# then expected one cycle later: valid0 valid1 head0 head1 (hex) empty full
1  0 0 0 0 0 0 0 0  00 00  0 0 00 00 1 0
1  0 0 0 0 0 0 0 0  00 00  0 0 00 00 1 0
2  0 0 1 0 0 0 0 0  00 00  0 0 00 00 1 0
2  1 1 0 0 0 0 0 0  11 12  1 1 11 12 0 0
2  1 0 0 0 0 0 0 0  13 00  1 1 11 12 0 0
2  1 1 0 0 0 0 0 0  14 15  1 1 11 12 0 0
2  0 0 0 0 0 0 0 0  00 00  1 1 11 12 0 0
3  0 0 0 0 0 1 0 0  00 00  0 0 00 00 1 0
3  1 1 0 0 0 0 0 0  21 22  0 0 00 00 1 0
3  1 0 0 0 0 0 0 0  23 00  0 0 00 00 1 0
4  1 1 0 1 0 0 0 0  31 32  1 1 31 32 0 0
4  1 0 0 0 0 0 0 0  33 00  1 1 31 32 0 0
4  1 1 0 0 0 0 0 0  34 35  1 1 31 32 0 0
4  0 0 0 0 0 0 1 0  00 00  1 1 31 32 0 0
4  1 1 0 0 0 0 0 0  00 00  1 1 33 34 0 0
4  1 0 0 0 0 0 0 0  00 00  1 1 34 35 0 0
4  0 0 0 0 0 0 0 0  00 00  1 1 34 35 0 0
4  1 1 0 0 0 0 0 0  00 00  0 0 00 00 1 0
4  1 1 0 0 0 0 0 0  3a 3b  0 0 00 00 1 0
5  1 1 1 0 0 0 0 0  41 42  1 1 41 42 0 0
5  1 1 0 0 0 0 0 0  43 44  1 1 41 42 0 0
5  1 1 0 0 0 0 0 0  45 46  1 1 41 42 0 0
5  1 0 0 0 0 0 0 0  47 00  1 1 41 42 0 0
5  1 1 0 0 0 0 0 0  48 49  1 1 41 42 0 1
5  1 1 0 0 0 0 0 0  4a 4b  1 1 41 42 0 1
5  0 0 0 0 0 0 0 1  00 00  1 1 41 42 0 1
5  1 1 0 0 0 0 0 0  00 00  1 1 43 44 0 0
5  1 1 0 0 0 0 0 0  00 00  1 1 45 46 0 0
5  1 0 0 0 0 0 0 0  00 00  1 1 46 47 0 0
5  1 0 0 0 0 0 0 0  00 00  1 1 47 48 0 0
5  1 1 0 0 0 0 0 0  00 00  0 0 00 00 1 0
5  0 0 0 0 0 0 0 0  00 00  0 0 00 00 1 0

// ==== filelist.f ====
+incdir+.
ib_replay_pkg.sv
ib_replay_ctl.sv
ib_slot_array.sv
ib_replay_fifo.sv
ib_replay_sva.sv
tb_ib_replay_fifo.sv

// ==== Bender.yml ====
package:
  name: ib_replay

sources:
  - include_dirs:
      - .
    files:
      - ib_replay_pkg.sv
      - ib_replay_ctl.sv
      - ib_slot_array.sv
      - ib_replay_fifo.sv
      - target: simulation
        include_dirs:
          - .
        files:
          - ib_replay_sva.sv
          - tb_ib_replay_fifo.sv

// ==== tb_ib_replay_fifo.sv ====
// replay queue testbench: file-driven lane traffic with head, empty and full checks
`timescale 1ns/1ps
`include "ib_replay_defs.svh"

module tb_ib_replay_fifo;

   import ib_replay_pkg::*;

   // one stimulus line, expectations apply a cycle later
   typedef struct packed {
      logic [7:0] test_num;
      logic [1:0] decode;      // {i0, i1}
      logic [1:0] block;
      logic [1:0] match;
      logic [1:0] flush;
      logic [7:0] tag0;
      logic [7:0] tag1;
      logic [1:0] exp_valid;   // {valid0, valid1}
      logic [7:0] exp_tag0;
      logic [7:0] exp_tag1;
      logic       exp_empty;
      logic       exp_full;
   } vec_t;

   logic          clk;
   logic          rst;
   logic          i0_decode;
   logic          i1_decode;
   logic          i0_load_block;
   logic          i1_load_block;
   logic          i0_load_match_e4;
   logic          i1_load_match_e4;
   logic          i0_flush_vp_e4;
   logic          i1_flush_vp_e4;
   ib_lane_pair_t lanes;
   ib_head_t      head;
   logic          fifo_empty;
   logic          fifo_full;

   vec_t vecs[$];
   bit   loaded;
   int   cycle_limit;
   int   cycles;
   int   errors;
   int   checks;
   int   test_errors;
   int   test_checks;
   int   tests_done;

   ib_replay_fifo i_dut (
      .clk              (clk),
      .rst              (rst),
      .i0_decode        (i0_decode),
      .i1_decode        (i1_decode),
      .i0_load_block    (i0_load_block),
      .i1_load_block    (i1_load_block),
      .i0_load_match_e4 (i0_load_match_e4),
      .i1_load_match_e4 (i1_load_match_e4),
      .i0_flush_vp_e4   (i0_flush_vp_e4),
      .i1_flush_vp_e4   (i1_flush_vp_e4),
      .lanes            (lanes),
      .head             (head),
      .fifo_empty       (fifo_empty),
      .fifo_full        (fifo_full)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // spread the tag over all three fields so a swapped field shows up
   function automatic ib_entry_t entry_from_tag(input logic [7:0] tag);
      ib_entry_t e;
      e.instr = {tag, ~tag, 8'h5a, tag};
      e.cinst = {~tag, tag};
      e.pc    = {{(`IB_PC_W-16){1'b0}}, tag, 8'h80};
      return e;
   endfunction

   task automatic load_vectors(output bit ok);
      int    fd;
      int    n;
      int    f[17];
      string line;
      vec_t  v;
      ok = 1'b0;
      fd = $fopen("ib_replay_testdata.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open ib_replay_testdata.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n == 0 || line.len() < 2 || line[0] == "#") continue;   // blank or column notes
         n = $sscanf(line, "%d %b %b %b %b %b %b %b %b %h %h %b %b %h %h %b %b",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                     f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
         if (n != 17) begin
            $display("ERROR: malformed stimulus line: %s", line);
            $fclose(fd);
            return;
         end
         v.test_num  = 8'(f[0]);
         v.decode    = {f[1][0], f[2][0]};
         v.block     = {f[3][0], f[4][0]};
         v.match     = {f[5][0], f[6][0]};
         v.flush     = {f[7][0], f[8][0]};
         v.tag0      = 8'(f[9]);
         v.tag1      = 8'(f[10]);
         v.exp_valid = {f[11][0], f[12][0]};
         v.exp_tag0  = 8'(f[13]);
         v.exp_tag1  = 8'(f[14]);
         v.exp_empty = f[15][0];
         v.exp_full  = f[16][0];
         vecs.push_back(v);
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
      if (!ok) $display("ERROR: no stimulus lines in ib_replay_testdata.txt");
   endtask

   task automatic drive_inputs(input vec_t v);
      {i0_decode, i1_decode}               = v.decode;
      {i0_load_block, i1_load_block}       = v.block;
      {i0_load_match_e4, i1_load_match_e4} = v.match;
      {i0_flush_vp_e4, i1_flush_vp_e4}     = v.flush;
      lanes.i0 = entry_from_tag(v.tag0);
      lanes.i1 = entry_from_tag(v.tag1);
   endtask

   task automatic record_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_outputs(input int idx);
      vec_t v;
      v = vecs[idx];
      checks++;
      test_checks++;
      assert (head.valid0 === v.exp_valid[1]) else begin
         $display("MISMATCH %0t: line %0d head.valid0 is %b, expected %b",
                  $time, idx + 1, head.valid0, v.exp_valid[1]);
         record_error();
      end
      assert (head.valid1 === v.exp_valid[0]) else begin
         $display("MISMATCH %0t: line %0d head.valid1 is %b, expected %b",
                  $time, idx + 1, head.valid1, v.exp_valid[0]);
         record_error();
      end
      assert (fifo_empty === v.exp_empty) else begin
         $display("MISMATCH %0t: line %0d fifo_empty is %b, expected %b",
                  $time, idx + 1, fifo_empty, v.exp_empty);
         record_error();
      end
      assert (fifo_full === v.exp_full) else begin
         $display("MISMATCH %0t: line %0d fifo_full is %b, expected %b",
                  $time, idx + 1, fifo_full, v.exp_full);
         record_error();
      end
      // payload only matters in a valid slot
      if (v.exp_valid[1]) begin
         assert (head.entry0 === entry_from_tag(v.exp_tag0)) else begin
            $display("MISMATCH %0t: line %0d head.entry0 is %h, expected tag %h",
                     $time, idx + 1, head.entry0, v.exp_tag0);
            record_error();
         end
      end
      if (v.exp_valid[0]) begin
         assert (head.entry1 === entry_from_tag(v.exp_tag1)) else begin
            $display("MISMATCH %0t: line %0d head.entry1 is %h, expected tag %h",
                     $time, idx + 1, head.entry1, v.exp_tag1);
            record_error();
         end
      end
   endtask

   task automatic report_test(input int num);
      $display("test %0d %s: %0d checks, %0d errors",
               num, (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
      tests_done++;
      test_checks = 0;
      test_errors = 0;
   endtask

   initial begin : watchdog
      cycles = 0;
      wait (loaded);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
   end

   initial begin : main
      bit ok;
      rst              = 1'b1;
      i0_decode        = 1'b0;
      i1_decode        = 1'b0;
      i0_load_block    = 1'b0;
      i1_load_block    = 1'b0;
      i0_load_match_e4 = 1'b0;
      i1_load_match_e4 = 1'b0;
      i0_flush_vp_e4   = 1'b0;
      i1_flush_vp_e4   = 1'b0;
      lanes            = '0;
      errors           = 0;
      checks           = 0;
      test_errors      = 0;
      test_checks      = 0;
      tests_done       = 0;
      load_vectors(ok);
      if (!ok) begin
         $display("TEST FAIL");
         $finish;
      end else begin
         cycle_limit = 2 * vecs.size() + 20;
         loaded = 1'b1;
         repeat (4) @(posedge clk);
         #2;
         rst = 1'b0;
         for (int n = 0; n <= vecs.size(); n++) begin
            @(posedge clk);
            #1;   // registered outputs settled, next drive not yet applied
            if (n > 0) begin
               check_outputs(n - 1);
               if (n == vecs.size() || vecs[n].test_num != vecs[n-1].test_num) begin
                  report_test(vecs[n-1].test_num);
               end
            end
            #1;
            if (n < vecs.size()) drive_inputs(vecs[n]);
         end
         $display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                  tests_done, checks, errors, i_dut.i_ctl.i_sva.fail_count);
         if (errors == 0 && i_dut.i_ctl.i_sva.fail_count == 0) begin
            $display("TEST PASS");
         end else begin
            $display("TEST FAIL");
         end
         $finish;
      end
   end

endmodule

// ==== ib_replay_sva.sv ====
// replay queue control checks: write and drain exclusivity, clear and occupancy consistency
`timescale 1ns/1ps
`include "ib_replay_defs.svh"

module ib_replay_sva (
   input logic                      clk,
   input logic                      rst,
   input logic                      accept_i0,
   input logic                      accept_i1,
   input ib_replay_pkg::ib_shift_t  shift,
   input logic                      clear,
   input logic                      fifo_empty,
   input logic [`IB_DEPTH-1:0]      occupancy
);

   import ib_replay_pkg::*;

   int fail_count = 0;   // read back by the testbench

   // a lane write and a drain never share a cycle
   a_no_write_while_shift: assert property (@(posedge clk) disable iff (rst)
      (accept_i0 | accept_i1) |-> (shift == shift_none))
      else begin
         $error("lane accepted while the queue shifts");
         fail_count++;
      end

   // correct prediction drops everything in one cycle
   a_clear_then_empty: assert property (@(posedge clk) disable iff (rst)
      clear |=> fifo_empty)
      else begin
         $error("queue not empty one cycle after clear");
         fail_count++;
      end

   // valid slots form one block from slot 0, no holes
   a_occupancy_packed: assert property (@(posedge clk) disable iff (rst)
      (occupancy & (occupancy + 1'b1)) == '0)
      else begin
         $error("queue occupancy has a hole below a valid slot");
         fail_count++;
      end

endmodule

bind ib_replay_ctl ib_replay_sva i_sva (
   .clk        (clk),
   .rst        (rst),
   .accept_i0  (accept_i0),
   .accept_i1  (accept_i1),
   .shift      (shift),
   .clear      (clear),
   .fifo_empty (fifo_empty),
   .occupancy  (occupancy)
);

// ==== ib_replay_fifo.sv ====
// replay queue top: mode control driving the shifting slot array
`timescale 1ns/1ps
`include "ib_replay_defs.svh"

module ib_replay_fifo (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          i0_decode,
   input  logic                          i1_decode,
   input  logic                          i0_load_block,
   input  logic                          i1_load_block,
   input  logic                          i0_load_match_e4,
   input  logic                          i1_load_match_e4,
   input  logic                          i0_flush_vp_e4,
   input  logic                          i1_flush_vp_e4,

   input  ib_replay_pkg::ib_lane_pair_t  lanes,

   output ib_replay_pkg::ib_head_t       head,
   output logic                          fifo_empty,
   output logic                          fifo_full
);

   import ib_replay_pkg::*;

   logic                  accept_i0;
   logic                  accept_i1;
   logic                  clear;
   ib_shift_t             shift;
   logic [`IB_DEPTH-1:0]  occupancy;   // slot valids back to control

   ib_replay_ctl i_ctl (
      .clk              (clk),
      .rst              (rst),
      .i0_decode        (i0_decode),
      .i1_decode        (i1_decode),
      .i0_load_block    (i0_load_block),
      .i1_load_block    (i1_load_block),
      .i0_load_match_e4 (i0_load_match_e4),
      .i1_load_match_e4 (i1_load_match_e4),
      .i0_flush_vp_e4   (i0_flush_vp_e4),
      .i1_flush_vp_e4   (i1_flush_vp_e4),
      .occupancy        (occupancy),
      .accept_i0        (accept_i0),
      .accept_i1        (accept_i1),
      .shift            (shift),
      .clear            (clear),
      .fifo_empty       (fifo_empty),
      .fifo_full        (fifo_full)
   );

   ib_slot_array i_slots (
      .clk       (clk),
      .rst       (rst),
      .accept_i0 (accept_i0),
      .accept_i1 (accept_i1),
      .shift     (shift),
      .clear     (clear),
      .lanes     (lanes),
      .occupancy (occupancy),
      .head      (head)
   );

endmodule

// ==== ib_slot_array.sv ====
// replay queue storage: eight shifting slots with valid bits, lane placement and drain
`timescale 1ns/1ps
`include "ib_replay_defs.svh"

module ib_slot_array (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          accept_i0,
   input  logic                          accept_i1,
   input  ib_replay_pkg::ib_shift_t      shift,
   input  logic                          clear,        // correct prediction
   input  ib_replay_pkg::ib_lane_pair_t  lanes,

   output logic [`IB_DEPTH-1:0]          occupancy,
   output ib_replay_pkg::ib_head_t       head
);

   import ib_replay_pkg::*;

   localparam int ENTRY_W = $bits(ib_entry_t);

   logic [`IB_DEPTH-1:0]   valid;
   logic [`IB_DEPTH-1:0]   valid_nxt;
   logic [`IB_DEPTH+1:0]   valid_ext;     // two empty slots above the top

   logic [`IB_DEPTH-1:0]   lower_vld;     // slot below is occupied
   logic [`IB_DEPTH-1:0]   first_empty;

   logic [`IB_DEPTH-1:0]   wr_i0;         // per-slot write selects
   logic [`IB_DEPTH-1:0]   wr_i1;
   logic [`IB_DEPTH-1:0]   sh_one;        // slot k takes slot k+1
   logic [`IB_DEPTH-1:0]   sh_two;        // slot k takes slot k+2
   logic [`IB_DEPTH-1:0]   slot_en;

   ib_entry_t              slots    [`IB_DEPTH];
   ib_entry_t              slot_ext [`IB_DEPTH+2];

   // padding keeps the shift sources uniform for the top two slots
   assign valid_ext = {2'b00, valid};

   always_comb begin
      for (int k = 0; k < `IB_DEPTH; k++) begin
         slot_ext[k] = slots[k];
      end
      slot_ext[`IB_DEPTH]   = '0;
      slot_ext[`IB_DEPTH+1] = '0;
   end

   // occupancy is contiguous from slot 0, so the first hole is unique
   assign lower_vld   = {valid[`IB_DEPTH-2:0], 1'b1};
   assign first_empty = lower_vld & ~valid;

   assign wr_i0 = {`IB_DEPTH{accept_i0}} & first_empty;

   // i1 lands one above i0, or in the first hole when i0 was not taken
   assign wr_i1 = {`IB_DEPTH{accept_i1}} &
                  (accept_i0 ? {first_empty[`IB_DEPTH-2:0], 1'b0} : first_empty);

   // only move entries that exist
   assign sh_one = {`IB_DEPTH{shift == shift_one}} & valid_ext[`IB_DEPTH:1];
   assign sh_two = {`IB_DEPTH{shift == shift_two}} & valid_ext[`IB_DEPTH+1:2];

   assign slot_en = wr_i0 | wr_i1 | sh_one | sh_two;

   always_comb begin
      case (shift)
         shift_one: valid_nxt = valid_ext[`IB_DEPTH:1];
         shift_two: valid_nxt = valid_ext[`IB_DEPTH+1:2];
         default:   valid_nxt = valid | wr_i0 | wr_i1;
      endcase
      if (clear) begin
         valid_nxt = '0;   // flushes everything, payload left stale
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else begin
         valid <= valid_nxt;
      end
   end

   for (genvar k = 0; k < `IB_DEPTH; k++) begin : g_slot
      ib_entry_t slot_nxt;

      // selects are one-hot per slot, so an and-or mux is enough
      assign slot_nxt = ({ENTRY_W{wr_i0[k]}}  & lanes.i0)      |
                        ({ENTRY_W{wr_i1[k]}}  & lanes.i1)      |
                        ({ENTRY_W{sh_one[k]}} & slot_ext[k+1]) |
                        ({ENTRY_W{sh_two[k]}} & slot_ext[k+2]);

      always_ff @(posedge clk) begin
         if (slot_en[k]) begin
            slots[k] <= slot_nxt;
         end
      end
   end

   assign occupancy = valid;

   // head pair goes back to decode in replay
   assign head = '{valid0: valid[0],
                   valid1: valid[1],
                   entry0: slots[0],
                   entry1: slots[1]};

endmodule

// ==== ib_replay_ctl.sv ====
// replay queue control: held and replay mode state, lane acceptance, shift selection
`timescale 1ns/1ps
`include "ib_replay_defs.svh"

module ib_replay_ctl (
   input  logic                      clk,
   input  logic                      rst,

   input  logic                      i0_decode,         // decoded, or head consumed in replay
   input  logic                      i1_decode,

   input  logic                      i0_load_block,     // dependent on predicted load
   input  logic                      i1_load_block,

   input  logic                      i0_load_match_e4,  // the load has reached e4
   input  logic                      i1_load_match_e4,
   input  logic                      i0_flush_vp_e4,    // predicted value was wrong
   input  logic                      i1_flush_vp_e4,

   input  logic [`IB_DEPTH-1:0]      occupancy,

   output logic                      accept_i0,
   output logic                      accept_i1,
   output ib_replay_pkg::ib_shift_t  shift,
   output logic                      clear,
   output logic                      fifo_empty,
   output logic                      fifo_full
);

   import ib_replay_pkg::*;

   logic correct;       // value prediction confirmed
   logic mispredict;    // value prediction failed
   logic write_mode;
   logic replay_mode;
   logic held_q;
   logic replay_q;

   assign fifo_empty = ~(|occupancy);
   assign fifo_full  = &occupancy;

   // a lane only counts as correct if it did not also flush
   assign correct    = (i0_load_match_e4 & ~i0_flush_vp_e4) |
                       (i1_load_match_e4 & ~i1_flush_vp_e4);
   assign mispredict = i0_flush_vp_e4 | i1_flush_vp_e4;

   // held state is sticky until either outcome arrives
   // a mispredict ends it too, so writing never overlaps replay
   assign write_mode  = (i0_load_block | i1_load_block | held_q) & ~correct & ~mispredict;

   // replay starts in the flush cycle itself and runs until drained
   assign replay_mode = (mispredict | replay_q) & ~fifo_empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         held_q   <= 1'b0;
         replay_q <= 1'b0;
      end else begin
         held_q   <= write_mode;
         replay_q <= replay_mode;
      end
   end

   // room check on the top two slots only
   // i1 cannot slip in without i0 since slot 6 fills before slot 7
   assign accept_i0 = write_mode & i0_decode & ~occupancy[`IB_DEPTH-1];
   assign accept_i1 = write_mode & i1_decode & ~occupancy[`IB_DEPTH-2];

   assign clear = correct;   // drop the whole queue

   always_comb begin
      shift = shift_none;
      if (replay_mode) begin
         if (i0_decode & i1_decode) begin
            shift = shift_two;   // both head slots consumed
         end else if (i0_decode) begin
            shift = shift_one;
         end
      end
   end

endmodule

// ==== ib_replay_pkg.sv ====
// replay queue types shared by the control, the slot array and the testbench
`include "ib_replay_defs.svh"

package ib_replay_pkg;

   // one queued instruction, 79 bits
   typedef struct packed {
      logic [`IB_INSTR_W-1:0] instr;
      logic [`IB_CINST_W-1:0] cinst;
      logic [`IB_PC_W-1:0]    pc;
   } ib_entry_t;

   // both decode lanes, i0 is older
   typedef struct packed {
      ib_entry_t i0;
      ib_entry_t i1;
   } ib_lane_pair_t;

   // head slots presented back to decode during replay
   typedef struct packed {
      logic      valid0;
      logic      valid1;
      ib_entry_t entry0;   // slot 0
      ib_entry_t entry1;   // slot 1
   } ib_head_t;

   // how far the queue moves down this cycle
   typedef enum logic [1:0] {
      shift_none = 2'd0,
      shift_one  = 2'd1,
      shift_two  = 2'd2
   } ib_shift_t;

endpackage

// ==== ib_replay_defs.svh ====
// replay queue sizing, depth of the shifting queue and widths of each stored field
`ifndef IB_REPLAY_DEFS_SVH
`define IB_REPLAY_DEFS_SVH

// number of queue slots
// placement and full detection assume slots fill from 0 upward
`define IB_DEPTH    8

// full 32b instruction word as seen at decode
`define IB_INSTR_W  32

// 16b compressed form, kept alongside the expanded word
`define IB_CINST_W  16

// halfword aligned pc, bit 0 dropped
`define IB_PC_W     31

`endif
